/* calypso.f */
calypso_pkg.sv
status_spi.sv
image_loader.sv
pixel_fetch.sv
color_lane.sv
vga_out.sv
calypso_top.sv
calypso_checker.sv
calypso_monitor.sv
tb_calypso.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_calypso
FILELIST  ?= calypso.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tb_calypso.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end
endmodule

module tb_calypso;
    import calypso_pkg::*;

    localparam int VGA_BITS = 4;
    localparam int FB_SIZE  = 16 * 8;
    localparam int FBW      = $clog2(FB_SIZE);
    localparam int H_TOTAL  = 16 + 2 + 3 + 3;
    localparam int FRAME    = H_TOTAL * (8 + 1 + 2 + 1);
    localparam int SPI_HALF = 4;   // clk_sys cycles per sck phase

    logic                clk_sys;
    logic                reset;
    logic                spi_sck;
    logic                spi_di;
    logic                spi_ss2;
    logic                conf_data0;
    logic [VGA_BITS-1:0] vga_r;
    logic [VGA_BITS-1:0] vga_g;
    logic [VGA_BITS-1:0] vga_b;
    logic                vga_hs;
    logic                vga_vs;
    logic [1:0]          check_mode;   // 0 off, 1 idle pins, 2 frame compare
    logic [7:0]          shadow_fb [FB_SIZE];
    logic [31:0]         shadow_status;
    logic [31:0]         lfsr_state;
    int                  assert_fails;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(3)) clk_i (.clk(clk_sys), .reset(reset));

    calypso_top #(
        .VGA_BITS (VGA_BITS),
        .H_ACTIVE (16), .H_FRONT (2), .H_SYNC (3), .H_BACK (3),
        .V_ACTIVE (8),  .V_FRONT (1), .V_SYNC (2), .V_BACK (1)
    ) dut_i (
        .clk_sys (clk_sys), .reset (reset), .spi_sck (spi_sck), .spi_di (spi_di),
        .spi_ss2 (spi_ss2), .conf_data0 (conf_data0), .vga_r (vga_r), .vga_g (vga_g),
        .vga_b (vga_b), .vga_hs (vga_hs), .vga_vs (vga_vs)
    );

    calypso_monitor #(
        .VGA_BITS (VGA_BITS),
        .H_ACTIVE (16), .H_FRONT (2), .H_SYNC (3), .H_BACK (3),
        .V_ACTIVE (8),  .V_FRONT (1), .V_SYNC (2), .V_BACK (1)
    ) mon_i (
        .clk_sys (clk_sys), .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
        .vga_hs (vga_hs), .vga_vs (vga_vs)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout: %s", what);
        $display("test failed");
        $finish;
    endtask

    task automatic wait_reset_release();
        for (int n = 0; n < 20; n++) begin
            @(posedge clk_sys);
            if (!reset) begin
                #1;
                return;
            end
        end
        fail_timeout("reset was never released");
    endtask

    task automatic wait_vs_fall();
        logic prev;
        prev = vga_vs;
        for (int n = 0; n < 2 * FRAME; n++) begin
            tick(1);
            if (prev && !vga_vs) return;
            prev = vga_vs;
        end
        fail_timeout("vga_vs did not fall within two frames");
    endtask

    task automatic wait_hs_rise();
        logic prev;
        prev = vga_hs;
        for (int n = 0; n < 2 * H_TOTAL; n++) begin
            tick(1);
            if (!prev && vga_hs) return;
            prev = vga_hs;
        end
        fail_timeout("vga_hs did not rise within two lines");
    endtask

    task automatic rand_byte(output logic [7:0] b);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[6:0], lfsr_state[0]};
        end
        b = r;
    endtask

    task automatic spi_bit(input logic b);
        spi_di = b;
        tick(SPI_HALF);
        spi_sck = 1'b1;
        tick(SPI_HALF);
        spi_sck = 1'b0;
    endtask

    task automatic spi_byte(input logic [7:0] b);
        logic [7:0] s;
        s = b;
        for (int i = 0; i < 8; i++) begin
            spi_bit(s[7]);   // MSB first
            s = s << 1;
        end
    endtask

    task automatic download(input logic [7:0] index, input int count);
        logic [7:0] b;
        spi_ss2 = 1'b0;
        tick(SPI_HALF);
        spi_byte(index);
        for (int i = 0; i < count; i++) begin
            rand_byte(b);
            spi_byte(b);
            if (i < FB_SIZE) shadow_fb[FBW'(i)] = b;
        end
        tick(SPI_HALF);
        spi_ss2 = 1'b1;
        tick(4);
    endtask

    // Align moves the deselect just past an hsync pulse
    task automatic status_transfer(input logic [7:0] cmd, input logic [31:0] word,
                                   input int nbits, input logic align);
        logic [31:0] w;
        w = word;
        conf_data0 = 1'b0;
        tick(SPI_HALF);
        spi_byte(cmd);
        for (int i = 0; i < nbits; i++) begin
            spi_bit(w[31]);
            w = w << 1;
        end
        tick(SPI_HALF);
        if (align) wait_hs_rise();
        conf_data0 = 1'b1;
        tick(4);
    endtask

    task automatic set_status(input logic [31:0] word, input logic align);
        status_transfer(CMD_STATUS, word, 32, align);
        shadow_status = word;
    endtask

    task automatic check_frame();
        wait_vs_fall();
        check_mode = 2'd2;
        wait_vs_fall();
        check_mode = 2'd0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        spi_sck       = 1'b0;
        spi_di        = 1'b0;
        spi_ss2       = 1'b1;
        conf_data0    = 1'b1;
        check_mode    = 2'd1;   // Pins idle through reset
        shadow_status = '0;
        lfsr_state    = 32'he39ddf04;
        for (int i = 0; i < FB_SIZE; i++) shadow_fb[FBW'(i)] = '0;

        wait_reset_release();
        tick(2);
        check_mode = 2'd0;

        download(8'h01, FB_SIZE);
        check_frame();
        download(8'h02, FB_SIZE + 24);   // Tail must not wrap into the framebuffer
        check_frame();
        download(8'h03, 40);
        check_frame();

        set_status(32'h0000_0002, 1'b0);   // scan_25
        check_frame();
        set_status(32'h0000_0004, 1'b0);   // scan_50
        check_frame();
        set_status(32'h0000_0006, 1'b0);   // scan_75
        check_frame();
        status_transfer(8'h2a, 32'h0000_0000, 32, 1'b0);
        check_frame();
        status_transfer(CMD_STATUS, 32'h0000_0000, 20, 1'b0);
        check_frame();

        set_status(32'h0000_0001, 1'b1);   // soft_reset
        tick(4);
        check_mode = 2'd1;
        tick(FRAME + H_TOTAL);
        check_mode = 2'd0;
        set_status(32'h0000_0000, 1'b0);
        check_frame();
        tick(4);

        assert_fails = dut_i.chk_calypso.wr_fails
                     + dut_i.chk_calypso.download_fails
                     + dut_i.chk_calypso.hs_fails;
        $display("Checked %0d samples, %0d monitor errors, %0d assertion failures",
                 mon_i.check_count, mon_i.error_count, assert_fails);
        if (mon_i.error_count == 0 && assert_fails == 0 && mon_i.check_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* calypso_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module calypso_monitor #(
    parameter int VGA_BITS = 4,
    parameter int H_ACTIVE = 16,
    parameter int H_FRONT  = 2,
    parameter int H_SYNC   = 3,
    parameter int H_BACK   = 3,
    parameter int V_ACTIVE = 8,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 1
) (
    input  logic                clk_sys,
    input  logic [VGA_BITS-1:0] vga_r,
    input  logic [VGA_BITS-1:0] vga_g,
    input  logic [VGA_BITS-1:0] vga_b,
    input  logic                vga_hs,
    input  logic                vga_vs
);
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int FBW      = $clog2(H_ACTIVE * V_ACTIVE);
    localparam int PW       = 3 * VGA_BITS;

    int            error_count = 0;
    int            check_count = 0;
    int            h_pos = 0;
    int            v_pos = 0;
    int            h_next;
    int            v_next;
    logic          locked = 1'b0;
    logic          vs_prev = 1'b1;
    logic          hs_want;
    logic          vs_want;
    logic [FBW-1:0] fb_idx;
    logic [PW-1:0] got;
    logic [PW-1:0] want;

    // Bit repetition is a multiply by 0b1001001 or 0b01010101
    function automatic logic [PW-1:0] ref_pixel(input logic [7:0] pix, input logic odd,
                                                input logic [1:0] mode);
        int          lv [3];
        int          d;
        logic [PW-1:0] res;
        lv[0] = int'(pix[7:5]) * 73 / 2;
        lv[1] = int'(pix[4:2]) * 73 / 2;
        lv[2] = int'(pix[1:0]) * 85;
        res = '0;
        for (int c = 0; c < 3; c++) begin
            d = lv[c];
            if (odd) begin
                case (mode)
                    2'd1: d = d - d / 4;
                    2'd2: d = d / 2;
                    2'd3: d = d / 4;
                    default: d = lv[c];
                endcase
            end
            res = (res << VGA_BITS) | PW'(d >> (8 - VGA_BITS));
        end
        return res;
    endfunction

    always @(negedge clk_sys) begin
        h_next = (h_pos == H_TOTAL - 1) ? 0 : h_pos + 1;
        v_next = v_pos;
        if (h_pos == H_TOTAL - 1) v_next = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
        if (vs_prev && !vga_vs) begin   // Frame anchor
            if (locked && tb_calypso.check_mode == 2'd2 && (h_next != 0 || v_next != VS_START)) begin
                error_count++;
                $display("** Error at %0d ns: vsync fell at (%0d,%0d), expected (0,%0d)",
                         $time, h_next, v_next, VS_START);
            end
            h_pos  = 0;
            v_pos  = VS_START;
            locked = 1'b1;
        end else begin
            h_pos = h_next;
            v_pos = v_next;
        end
        vs_prev = vga_vs;
        got     = {vga_r, vga_g, vga_b};

        if (tb_calypso.check_mode == 2'd1) begin
            check_count++;
            locked = 1'b0;   // Raster phase restarts after an idle period
            if (got !== '0 || vga_hs !== 1'b1 || vga_vs !== 1'b1) begin
                error_count++;
                $display("** Error at %0d ns: outputs not idle, rgb %h hs %b vs %b",
                         $time, got, vga_hs, vga_vs);
            end
        end else if (tb_calypso.check_mode == 2'd2) begin
            check_count++;
            if (!locked) begin
                error_count++;
                $display("Frame check started before any vsync was seen");
            end
            hs_want = !(h_pos >= HS_START && h_pos < HS_START + H_SYNC);
            vs_want = !(v_pos >= VS_START && v_pos < VS_START + V_SYNC);
            want    = '0;   // Blanking
            if (h_pos < H_ACTIVE && v_pos < V_ACTIVE) begin
                fb_idx = FBW'(v_pos * H_ACTIVE + h_pos);
                want   = ref_pixel(tb_calypso.shadow_fb[fb_idx], (v_pos % 2) == 1,
                                   tb_calypso.shadow_status[2:1]);
            end
            if (vga_hs !== hs_want || vga_vs !== vs_want) begin
                error_count++;
                $display("** Error at %0d ns: syncs at (%0d,%0d) hs %b vs %b, expected %b %b",
                         $time, h_pos, v_pos, vga_hs, vga_vs, hs_want, vs_want);
            end
            if (got !== want) begin
                error_count++;
                $display("** Error at %0d ns: pixel (%0d,%0d) got %h expected %h",
                         $time, h_pos, v_pos, got, want);
            end
        end
    end

endmodule

`default_nettype wire

/* calypso_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module calypso_checker #(
    parameter int H_SYNC = 96
) (
    input logic clk_sys,
    input logic reset,
    input logic wr,
    input logic download,
    input logic hs
);
    int          wr_fails = 0;
    int          download_fails = 0;
    int          hs_fails = 0;
    logic [15:0] hs_low;   // Low cycles of the current pulse

    always_ff @(posedge clk_sys) begin
        if (reset || hs) begin
            hs_low <= '0;
        end else begin
            hs_low <= hs_low + 16'd1;
        end
    end

    wr_single: assert property (@(posedge clk_sys) disable iff (reset) wr |=> !wr)
        else begin wr_fails++; $error("ioctl write strobe high for two cycles"); end

    wr_in_download: assert property (@(posedge clk_sys) disable iff (reset) wr |-> download)
        else begin download_fails++; $error("ioctl write strobe outside a download"); end

    hs_width: assert property (@(posedge clk_sys) disable iff (reset)
                               $rose(hs) |-> hs_low == 16'(H_SYNC))
        else begin hs_fails++; $error("hsync low for %0d cycles", hs_low); end

endmodule

bind calypso_top calypso_checker #(.H_SYNC(H_SYNC)) chk_calypso (
    .clk_sys (clk_sys), .reset (reset), .wr (ioctl.wr), .download (ioctl.download),
    .hs (vga_hs)
);

`default_nettype wire

/* calypso_top.sv */
`timescale 1ns/10ps
`default_nettype none

module calypso_top #(
    parameter int VGA_BITS = 4,
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                spi_sck,
    input  logic                spi_di,
    input  logic                spi_ss2,      // data_io
    input  logic                conf_data0,   // SPI select for the status word
    output logic [VGA_BITS-1:0] vga_r,
    output logic [VGA_BITS-1:0] vga_g,
    output logic [VGA_BITS-1:0] vga_b,
    output logic                vga_hs,
    output logic                vga_vs
);
    import calypso_pkg::*;

    status_t                  status;
    ioctl_t                   ioctl;
    pixel_t                   pixel;
    logic [2:0][7:0]          lane_in;
    logic [2:0][VGA_BITS-1:0] lane_levels;

    status_spi status_spi (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .spi_sck    (spi_sck),
        .spi_di     (spi_di),
        .conf_data0 (conf_data0),
        .status     (status)
    );

    image_loader image_loader (
        .clk_sys (clk_sys),
        .reset   (reset),
        .spi_sck (spi_sck),
        .spi_di  (spi_di),
        .spi_ss2 (spi_ss2),
        .ioctl   (ioctl)
    );

    pixel_fetch #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) pixel_fetch (
        .clk_sys (clk_sys),
        .reset   (reset),
        .status  (status),
        .ioctl   (ioctl),
        .pixel   (pixel)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Colour lanes, 0 red, 1 green, 2 blue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign lane_in = {pixel.blue, pixel.green, pixel.red};

    for (genvar i = 0; i < 3; i++) begin : g_lane
        color_lane #(
            .VGA_BITS (VGA_BITS)
        ) color_lane (
            .clk_sys   (clk_sys),
            .reset     (reset),
            .level     (lane_in[i]),
            .blank     (pixel.blank),
            .odd_line  (pixel.odd_line),
            .scanlines (status.scanlines),
            .level_out (lane_levels[i])
        );
    end

    vga_out #(
        .VGA_BITS (VGA_BITS)
    ) vga_out (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .lane_levels (lane_levels),
        .hsync       (pixel.hsync),
        .vsync       (pixel.vsync),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs)
    );

endmodule

`default_nettype wire

/* vga_out.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_out #(
    parameter int VGA_BITS = 4
) (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  logic [2:0][VGA_BITS-1:0]      lane_levels,
    input  logic                          hsync,
    input  logic                          vsync,
    output logic [VGA_BITS-1:0]           vga_r,
    output logic [VGA_BITS-1:0]           vga_g,
    output logic [VGA_BITS-1:0]           vga_b,
    output logic                          vga_hs,
    output logic                          vga_vs
);

    logic hs_d;   // Matches the colour lane register
    logic vs_d;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hs_d   <= 1'b1;
            vs_d   <= 1'b1;
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
            vga_r  <= '0;
            vga_g  <= '0;
            vga_b  <= '0;
        end else begin
            hs_d   <= hsync;
            vs_d   <= vsync;
            vga_hs <= hs_d;
            vga_vs <= vs_d;
            vga_r  <= lane_levels[0];
            vga_g  <= lane_levels[1];
            vga_b  <= lane_levels[2];
        end
    end

endmodule

`default_nettype wire

/* color_lane.sv */
`timescale 1ns/10ps
`default_nettype none

module color_lane #(
    parameter int VGA_BITS = 4
) (
    input  logic                    clk_sys,
    input  logic                    reset,
    input  logic [7:0]              level,
    input  logic                    blank,
    input  logic                    odd_line,
    input  calypso_pkg::scan_mode_t scanlines,
    output logic [VGA_BITS-1:0]     level_out
);
    import calypso_pkg::*;

    logic [7:0] dimmed;

    always_comb begin
        dimmed = level;
        if (odd_line) begin   // Even lines pass untouched
            case (scanlines)
                scan_25: dimmed = level - (level >> 2);
                scan_50: dimmed = level >> 1;
                scan_75: dimmed = level >> 2;
                default: dimmed = level;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            level_out <= '0;
        end else if (blank) begin
            level_out <= '0;
        end else begin
            level_out <= dimmed[7 -: VGA_BITS];   // Keep the top bits
        end
    end

endmodule

`default_nettype wire

/* pixel_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_fetch #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  calypso_pkg::status_t status,
    input  calypso_pkg::ioctl_t  ioctl,
    output calypso_pkg::pixel_t  pixel
);
    import calypso_pkg::*;

    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int FB_SIZE  = H_ACTIVE * V_ACTIVE;
    localparam int AW       = $clog2(FB_SIZE);
    localparam int HW       = $clog2(H_TOTAL + 1);
    localparam int VW       = $clog2(V_TOTAL + 1);

    logic [7:0]    fb [FB_SIZE];
    logic          pix_reset;
    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          hs_c;
    logic          vs_c;
    logic          blank_c;
    logic [AW-1:0] rd_addr;
    logic [7:0]    rd_data;
    logic [3:0]    ctl_s1;   // {hsync, vsync, blank, odd_line}
    logic [3:0]    ctl_s2;

    assign pix_reset = reset | status.soft_reset;

    always_ff @(posedge clk_sys) begin
        if (ioctl.wr && ioctl.addr < 25'(FB_SIZE)) begin
            fb[ioctl.addr[AW-1:0]] <= ioctl.dout;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster counters and decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_sys) begin
        if (pix_reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == HW'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + VW'(1);
        end else begin
            h_cnt <= h_cnt + HW'(1);
        end
    end

    assign blank_c = (h_cnt >= HW'(H_ACTIVE)) || (v_cnt >= VW'(V_ACTIVE));
    assign hs_c    = !(h_cnt >= HW'(HS_START) && h_cnt < HW'(HS_START + H_SYNC));
    assign vs_c    = !(v_cnt >= VW'(VS_START) && v_cnt < VW'(VS_START + V_SYNC));

    // Stage 1 registers the address, stage 2 the read
    always_ff @(posedge clk_sys) begin
        rd_addr <= blank_c ? '0 : AW'(int'(v_cnt) * H_ACTIVE + int'(h_cnt));
        rd_data <= fb[rd_addr];
    end

    always_ff @(posedge clk_sys) begin
        if (pix_reset) begin
            ctl_s1 <= 4'b1110;   // Syncs inactive, blank
            ctl_s2 <= 4'b1110;
        end else begin
            ctl_s1 <= {hs_c, vs_c, blank_c, v_cnt[0]};
            ctl_s2 <= ctl_s1;
        end
    end

    // RGB332 to 8 bits per colour by bit repetition
    always_comb begin
        pixel.red      = {rd_data[7:5], rd_data[7:5], rd_data[7:6]};
        pixel.green    = {rd_data[4:2], rd_data[4:2], rd_data[4:3]};
        pixel.blue     = {4{rd_data[1:0]}};
        pixel.hsync    = ctl_s2[3];
        pixel.vsync    = ctl_s2[2];
        pixel.blank    = ctl_s2[1];
        pixel.odd_line = ctl_s2[0];
    end

endmodule

`default_nettype wire

/* image_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module image_loader (
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                spi_sck,
    input  logic                spi_di,
    input  logic                spi_ss2,
    output calypso_pkg::ioctl_t ioctl
);

    logic [2:0]  sck_sync;
    logic [1:0]  di_sync;
    logic        sck_rise;
    logic [2:0]  bit_cnt;
    logic [6:0]  byte_shift;
    logic [7:0]  byte_in;
    logic        have_index;
    logic        download_q;
    logic [7:0]  index_q;
    logic        wr_q;
    logic [24:0] addr_q;
    logic [7:0]  dout_q;

    assign sck_rise = sck_sync[1] & ~sck_sync[2];
    assign byte_in  = {byte_shift, di_sync[1]};   // Byte including the bit being taken

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sck_sync <= '0;
        end else begin
            sck_sync <= {sck_sync[1:0], spi_sck};
        end
        di_sync <= {di_sync[0], spi_di};
    end

    always_ff @(posedge clk_sys) begin
        if (sck_rise && !spi_ss2) begin
            byte_shift <= byte_in[6:0];
            if (bit_cnt == 3'd7 && have_index) begin
                dout_q <= byte_in;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Index byte first, every later byte is one write
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            bit_cnt    <= '0;
            have_index <= 1'b0;
            download_q <= 1'b0;
            index_q    <= '0;
            wr_q       <= 1'b0;
            addr_q     <= '0;
        end else begin
            wr_q <= 1'b0;
            if (wr_q) begin
                addr_q <= addr_q + 25'd1;   // Advance after each write
            end
            if (spi_ss2) begin
                bit_cnt    <= '0;
                have_index <= 1'b0;
                download_q <= 1'b0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    if (!have_index) begin
                        have_index <= 1'b1;
                        index_q    <= byte_in;
                        download_q <= 1'b1;
                        addr_q     <= '0;
                    end else begin
                        wr_q <= 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        ioctl.download = download_q;
        ioctl.index    = index_q;
        ioctl.wr       = wr_q;
        ioctl.addr     = addr_q;
        ioctl.dout     = dout_q;
    end

endmodule

`default_nettype wire

/* status_spi.sv */
`timescale 1ns/10ps
`default_nettype none

module status_spi (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 spi_sck,
    input  logic                 spi_di,
    input  logic                 conf_data0,
    output calypso_pkg::status_t status
);
    import calypso_pkg::*;

    logic [2:0]  sck_sync;
    logic [1:0]  di_sync;
    logic        sck_rise;
    logic        sel_q;
    logic [5:0]  bit_cnt;
    logic [6:0]  cmd_shift;
    logic        cmd_ok;
    logic [31:0] word_shift;
    logic [31:0] status_q;

    assign sck_rise = sck_sync[1] & ~sck_sync[2];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sck_sync <= '0;
        end else begin
            sck_sync <= {sck_sync[1:0], spi_sck};
        end
        di_sync <= {di_sync[0], spi_di};
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command byte, then 32 data bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_sys) begin
        if (reset || conf_data0) begin
            bit_cnt <= '0;
            cmd_ok  <= 1'b0;
        end else if (sck_rise) begin
            if (bit_cnt != 6'd63) begin
                bit_cnt <= bit_cnt + 6'd1;   // Saturates so overlong transfers are dropped
            end
            if (bit_cnt == 6'd7) begin
                cmd_ok <= ({cmd_shift, di_sync[1]} == CMD_STATUS);
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (sck_rise && !conf_data0) begin
            if (bit_cnt < 6'd8) begin
                cmd_shift <= {cmd_shift[5:0], di_sync[1]};
            end else if (bit_cnt < 6'd40) begin
                word_shift <= {word_shift[30:0], di_sync[1]};
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sel_q    <= 1'b1;
            status_q <= '0;
        end else begin
            sel_q <= conf_data0;
            if (conf_data0 && !sel_q && cmd_ok && bit_cnt == 6'd40) begin
                status_q <= word_shift;   // Commit on deselect
            end
        end
    end

    always_comb begin
        status.raw        = status_q;
        status.soft_reset = status_q[0];
        status.scanlines  = scan_mode_t'(status_q[2:1]);
    end

endmodule

`default_nettype wire

/* calypso_pkg.sv */
`default_nettype none

package calypso_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host link
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [7:0] CMD_STATUS = 8'h1e;   // Opens a status transfer on conf_data0

    typedef enum logic [1:0] {
        scan_off = 2'd0,
        scan_25  = 2'd1,
        scan_50  = 2'd2,
        scan_75  = 2'd3
    } scan_mode_t;

    // One download write, same fields as the data_io port set
    typedef struct packed {
        logic        download;
        logic [7:0]  index;
        logic        wr;
        logic [24:0] addr;
        logic [7:0]  dout;
    } ioctl_t;

    typedef struct packed {
        logic        soft_reset;   // Bit 0 of the option word
        scan_mode_t  scanlines;    // Bits 2:1
        logic [31:0] raw;
    } status_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Video
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic       hsync;      // Active low
        logic       vsync;      // Active low
        logic       blank;
        logic       odd_line;
    } pixel_t;

endpackage

`default_nettype wire
